/* riscv_biu_fsm.sv */
// axi4-lite read-only master for instruction fetch
// takes fetch strobes from the core, issues ar transfers one at a time
// and returns read data with the address it was fetched from
// stale responses are swallowed while drop is high
module riscv_biu_fsm #(
  parameter int max_outstanding = 2
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              biu_stb,
  input  logic [riscv_fetch_pkg::XLEN-1:0]  biu_adri,
  input  riscv_fetch_pkg::prv_e             st_prv,
  input  logic                              full,
  input  logic                              drop,
  output logic                              biu_stb_ack,
  output logic                              biu_rack,
  output logic [riscv_fetch_pkg::XLEN-1:0]  biu_do,
  output logic [riscv_fetch_pkg::XLEN-1:0]  biu_adro,
  output logic                              biu_err,
  output logic                              req_taken,
  output logic                              resp_taken,
  output logic [riscv_fetch_pkg::XLEN-1:0]  araddr,
  output logic [2:0]                        arprot,
  output logic                              arvalid,
  input  logic                              arready,
  input  logic [riscv_fetch_pkg::XLEN-1:0]  rdata,
  input  logic [1:0]                        rresp,
  input  logic                              rvalid,
  output logic                              rready
);

  import riscv_fetch_pkg::*;

  // pointer width, at least one bit even for a single entry
  localparam int ptr_w = (max_outstanding > 1) ? $clog2(max_outstanding) : 1;

  fetch_state_e     state;
  logic [XLEN-1:0]  adr_q [max_outstanding];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  // accept only between ar transfers and below the read limit
  assign biu_stb_ack = (state == ST_IDLE) && !full;
  assign req_taken   = biu_stb && biu_stb_ack;
  assign arvalid     = (state == ST_AR);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (req_taken) state <= ST_AR;
        ST_AR:   if (arready)   state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address and protection held until arready
  always_ff @(posedge clk) begin
    if (req_taken) begin
      araddr                 <= biu_adri;
      arprot[prot_priv]      <= (st_prv != PRV_U);
      arprot[prot_nonsecure] <= 1'b0;
      arprot[prot_instr]     <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // return address queue
  //////////////////////////////////////////////////////////////////////

  // responses come back in order, so a plain ring buffer is enough
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (req_taken) begin
        wr_ptr <= (wr_ptr == ptr_w'(max_outstanding - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (resp_taken) begin
        rd_ptr <= (rd_ptr == ptr_w'(max_outstanding - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_taken) begin
      adr_q[wr_ptr] <= biu_adri;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////

  // always ready once out of reset, the core never refuses data
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rready <= 1'b0;
    end else begin
      rready <= 1'b1;
    end
  end

  assign resp_taken = rvalid && rready;

  // stale data still pops the queue but never reaches the core
  assign biu_rack = resp_taken && !drop;
  assign biu_do   = rdata;
  assign biu_adro = adr_q[rd_ptr];
  assign biu_err  = (axi_resp_e'(rresp) != RESP_OKAY);

endmodule

/* riscv_fetch_checker.sv */
// scoreboard for the fetch front end
// predicts parcel pc, data, error and misaligned flags from reset_pc
// and the redirects seen on the cpu side, and checks the ar channel rules
module riscv_fetch_checker #(
  parameter logic [31:0] reset_pc        = '0,
  parameter int          max_outstanding = 2,
  parameter logic [31:0] data_xor        = 32'h5A5A_C3C3,
  parameter logic [31:0] err_lo          = '0,
  parameter logic [31:0] err_hi          = '0
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  redirect,
  input  logic [31:0]           redirect_pc,
  input  logic                  if_stall,
  input  logic                  dcflush_rdy,
  input  riscv_fetch_pkg::prv_e st_prv,
  input  logic [31:0]           if_parcel,
  input  logic [31:0]           if_parcel_pc,
  input  logic                  if_parcel_valid,
  input  logic                  if_parcel_misaligned,
  input  logic                  if_parcel_err,
  input  logic [2:0]            arprot,
  input  logic                  arvalid,
  input  logic                  arready,
  input  logic                  rvalid,
  input  logic                  rready,
  output int                    err_cnt,
  output int                    parcel_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  import riscv_fetch_pkg::*;

  logic [31:0] exp_pc;
  logic        exp_err;
  // previous-edge samples
  logic        redir_q;
  logic        arvalid_q;
  logic        dcflush_q;
  prv_e        prv_q;
  int          outstanding;

  task automatic mismatch_error(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic rule_error(input string what);
    $display("error at %0t: %s", $time, what);
    err_cnt++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // sampling at every rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      exp_pc      = reset_pc;
      redir_q     = 1'b0;
      arvalid_q   = 1'b0;
      dcflush_q   = 1'b0;
      prv_q       = PRV_U;
      outstanding = 0;
      err_cnt     = 0;
      parcel_cnt  = 0;
    end else begin
      // parcel stream toward the cpu
      if (if_parcel_valid) begin
        parcel_cnt++;
        if (redirect || redir_q) rule_error("parcel delivered within two cycles of redirect");
        if (if_stall) rule_error("parcel delivered while if_stall was high");
        exp_err = (exp_pc >= err_lo) && (exp_pc < err_hi);
        if (if_parcel_pc !== exp_pc) mismatch_error("if_parcel_pc", if_parcel_pc, exp_pc);
        if (if_parcel !== (exp_pc ^ data_xor)) begin
          mismatch_error("if_parcel", if_parcel, exp_pc ^ data_xor);
        end
        if (if_parcel_err !== exp_err) begin
          mismatch_error("if_parcel_err", 32'(if_parcel_err), 32'(exp_err));
        end
        if (if_parcel_misaligned !== (|exp_pc[1:0])) begin
          mismatch_error("if_parcel_misaligned", 32'(if_parcel_misaligned),
                         32'(|exp_pc[1:0]));
        end
        exp_pc = exp_pc + 32'd4;
      end
      // new stream starts at the target
      if (redirect) exp_pc = redirect_pc;
      // a fresh ar request was accepted at the previous edge
      if (arvalid && !arvalid_q) begin
        if (!dcflush_q) rule_error("read address issued while dcflush_rdy was low");
        if (arprot[prot_instr] !== 1'b1) begin
          mismatch_error("arprot[2]", 32'(arprot[prot_instr]), 32'd1);
        end
        if (arprot[prot_priv] !== (prv_q != PRV_U)) begin
          mismatch_error("arprot[0]", 32'(arprot[prot_priv]), 32'(prv_q != PRV_U));
        end
      end
      // reads in flight on the bus
      if (arvalid && arready) outstanding++;
      if (rvalid && rready) outstanding--;
      if (outstanding > max_outstanding) rule_error("more reads outstanding than allowed");
      redir_q   = redirect;
      arvalid_q = arvalid;
      dcflush_q = dcflush_rdy;
      prv_q     = st_prv;
    end
  end

endmodule

/* riscv_fetch_pkg.sv */
// shared constants and types for the cacheless instruction fetch front end
// imported by the fetch engine, the bus state machine and the top level
package riscv_fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // data and address width, fixed for this core
  localparam int XLEN = 32;

  // only full 32-bit parcels, no compressed support
  localparam int parcel_size = 32;

  //////////////////////////////////////////////////////////////////////
  // axi4-lite arprot bit positions
  //////////////////////////////////////////////////////////////////////

  localparam int prot_priv      = 0;
  localparam int prot_nonsecure = 1;
  localparam int prot_instr     = 2;

  //////////////////////////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////////////////////////

  // read master states
  typedef enum logic [0:0] {
    ST_IDLE,
    ST_AR
  } fetch_state_e;

  // cpu privilege level, as presented by the csr block
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_H = 2'b10,
    PRV_M = 2'b11
  } prv_e;

  // axi read response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

endpackage

/* riscv_fetch_sva.sv */
// protocol assertions for the axi4-lite read master
// bound into every riscv_biu_fsm instance, watches ar, r and the drop path
// fail_cnt is read by the testbench for its closing summary
module riscv_fetch_sva_chk (
  input logic        clk,
  input logic        rstn,
  input logic [31:0] araddr,
  input logic [2:0]  arprot,
  input logic        arvalid,
  input logic        arready,
  input logic        rready,
  input logic        resp_taken,
  input logic        drop
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  // ar request may not be withdrawn while the slave waits
  a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    arvalid && !arready |=> arvalid)
    else begin
      fail_cnt++;
      $error("arvalid dropped before arready");
    end

  // address and protection frozen during the wait
  a_ar_stable: assert property (@(posedge clk) disable iff (!rstn)
    arvalid && !arready |=> $stable(araddr) && $stable(arprot))
    else begin
      fail_cnt++;
      $error("araddr or arprot changed while arvalid waited");
    end

  // once up, rready stays up
  a_rready: assert property (@(posedge clk) disable iff (!rstn)
    rready |=> rready)
    else begin
      fail_cnt++;
      $error("rready fell after reset");
    end

  // stale marking only clears when a response is consumed
  a_drop_until_resp: assert property (@(posedge clk) disable iff (!rstn)
    drop && !resp_taken |=> drop)
    else begin
      fail_cnt++;
      $error("drop fell without a response being taken");
    end

endmodule

bind riscv_biu_fsm riscv_fetch_sva_chk sva_i (
  .clk        (clk),
  .rstn       (rstn),
  .araddr     (araddr),
  .arprot     (arprot),
  .arvalid    (arvalid),
  .arready    (arready),
  .rready     (rready),
  .resp_taken (resp_taken),
  .drop       (drop)
);

/* riscv_fetch_tb.sv */
// testbench for the cacheless fetch front end
// applies a row table of redirects, stalls and dcflush gaps,
// models an axi4-lite read slave with random ar and r delays
module riscv_fetch_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import riscv_fetch_pkg::*;

  localparam logic [31:0] reset_pc        = 32'h0000_1000;
  localparam int          max_outstanding = 2;
  // memory pattern and slave error window
  localparam logic [31:0] data_xor        = 32'h5A5A_C3C3;
  localparam logic [31:0] err_lo          = 32'h0000_2000;
  localparam logic [31:0] err_hi          = 32'h0000_2010;
  localparam int          n_rows          = 6;

  // one test per row
  typedef struct packed {
    logic        jump;
    logic [31:0] target;
    prv_e        prv;
    logic [7:0]  parcels;
    logic [7:0]  stall_pat;
    logic [3:0]  dc_gap;
  } row_t;

  logic clk;
  logic rstn;
  logic redirect;
  logic [31:0] redirect_pc;
  logic if_stall;
  logic dcflush_rdy;
  prv_e st_prv;
  logic [31:0] if_parcel;
  logic [31:0] if_parcel_pc;
  logic if_parcel_valid;
  logic if_parcel_misaligned;
  logic if_parcel_err;
  logic [31:0] araddr;
  logic [2:0] arprot;
  logic arvalid;
  logic arready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  int err_cnt;
  int parcel_cnt;

  row_t        rows [n_rows];
  int          ar_dly [64];
  int          r_dly [64];
  logic [31:0] rd_q [$];

  function automatic logic in_err_window(input logic [31:0] adr);
    return (adr >= err_lo) && (adr < err_hi);
  endfunction

  riscv_fetch_top #(.reset_pc(reset_pc), .max_outstanding(max_outstanding)) dut_i (.*);

  riscv_fetch_checker #(
    .reset_pc (reset_pc), .max_outstanding (max_outstanding),
    .data_xor (data_xor), .err_lo (err_lo), .err_hi (err_hi)
  ) checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // axi read slave, in-order responses
  //////////////////////////////////////////////////////////////////////

  initial begin : ar_slave
    int ar_n;
    ar_n    = 0;
    arready = 1'b0;
    forever begin
      @(negedge clk);
      if (arvalid) begin
        repeat (ar_dly[ar_n % 64]) @(negedge clk);
        ar_n++;
        arready = 1'b1;
        @(posedge clk);
        rd_q.push_back(araddr);
        @(negedge clk);
        arready = 1'b0;
      end
    end
  end

  initial begin : r_slave
    int          r_n;
    logic [31:0] adr;
    r_n    = 0;
    rvalid = 1'b0;
    rdata  = '0;
    rresp  = RESP_OKAY;
    forever begin
      @(negedge clk);
      if (rd_q.size() != 0) begin
        repeat (r_dly[r_n % 64]) @(negedge clk);
        r_n++;
        adr    = rd_q.pop_front();
        rdata  = adr ^ data_xor;
        rresp  = in_err_window(adr) ? RESP_SLVERR : RESP_OKAY;
        rvalid = 1'b1;
        do @(posedge clk); while (!rready);
        @(negedge clk);
        rvalid = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int got;
    int cyc;
    void'($urandom(47811));
    for (int i = 0; i < 64; i++) begin
      ar_dly[i] = $urandom_range(3);
      r_dly[i]  = $urandom_range(3);
    end
    // jump, target, privilege, parcels, stall pattern, dcflush gap
    rows[0] = '{1'b0, 32'h0000_0000, PRV_M, 8'd12, 8'b0000_0000, 4'd0};
    rows[1] = '{1'b1, 32'h0000_3000, PRV_U, 8'd10, 8'b0011_0110, 4'd0};
    rows[2] = '{1'b1, 32'h0000_1FF8, PRV_S, 8'd10, 8'b0000_0000, 4'd0};
    rows[3] = '{1'b1, 32'h0000_0402, PRV_U, 8'd4,  8'b0000_0000, 4'd0};
    rows[4] = '{1'b1, 32'h0000_0800, PRV_H, 8'd8,  8'b0000_0000, 4'd6};
    rows[5] = '{1'b1, 32'h0000_5000, PRV_M, 8'd12, 8'b1000_1100, 4'd3};
    rstn        = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    if_stall    = 1'b0;
    dcflush_rdy = 1'b1;
    st_prv      = PRV_M;
    repeat (3) @(negedge clk);
    rstn = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      @(negedge clk);
      st_prv = rows[r].prv;
      if (rows[r].jump) begin
        redirect    = 1'b1;
        redirect_pc = rows[r].target;
      end
      if (rows[r].dc_gap != 0) dcflush_rdy = 1'b0;
      @(negedge clk);
      redirect = 1'b0;
      if (rows[r].dc_gap != 0) begin
        repeat (rows[r].dc_gap) @(negedge clk);
        dcflush_rdy = 1'b1;
      end
      // stall bits rotate every cycle until enough parcels went by
      got = 0;
      cyc = 0;
      while (got < int'(rows[r].parcels)) begin
        @(posedge clk);
        if (if_parcel_valid) got++;
        @(negedge clk);
        if_stall = rows[r].stall_pat[cyc % 8];
        cyc++;
      end
      if_stall = 1'b0;
    end
    repeat (4) @(negedge clk);
    $display("summary: %0d parcels checked, %0d checker errors, %0d assertion failures",
             parcel_cnt, err_cnt, dut_i.biu_fsm_i.sva_i.fail_cnt);
    if (err_cnt == 0 && dut_i.biu_fsm_i.sva_i.fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // budget of 40 cycles per parcel over all rows
  initial begin : watchdog
    int limit;
    #1;
    limit = 0;
    for (int i = 0; i < n_rows; i++) limit += int'(rows[i].parcels) * 40;
    repeat (limit) @(posedge clk);
    $display("timeout: fetch stopped delivering parcels within %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* riscv_fetch_top.f */
riscv_fetch_pkg.sv
riscv_pc_gen.sv
riscv_inflight_cnt.sv
riscv_biu_fsm.sv
riscv_noicache_core.sv
riscv_fetch_top.sv
riscv_fetch_sva.sv
riscv_fetch_checker.sv
riscv_fetch_tb.sv

/* riscv_fetch_top.sv */
// instruction fetch front end without cache
// cpu fetch interface on one side, axi4-lite read master on the other
// reset_pc and max_outstanding are set here and passed down
module riscv_fetch_top #(
  parameter logic [riscv_fetch_pkg::XLEN-1:0] reset_pc        = '0,
  parameter int                               max_outstanding = 2
) (
  input  logic                                    clk,
  input  logic                                    rstn,
  // cpu side
  input  logic                                    redirect,
  input  logic [riscv_fetch_pkg::XLEN-1:0]        redirect_pc,
  input  logic                                    if_stall,
  input  logic                                    dcflush_rdy,
  input  riscv_fetch_pkg::prv_e                   st_prv,
  output logic [riscv_fetch_pkg::parcel_size-1:0] if_parcel,
  output logic [riscv_fetch_pkg::XLEN-1:0]        if_parcel_pc,
  output logic                                    if_parcel_valid,
  output logic                                    if_parcel_misaligned,
  output logic                                    if_parcel_err,
  // axi read port
  output logic [riscv_fetch_pkg::XLEN-1:0]        araddr,
  output logic [2:0]                              arprot,
  output logic                                    arvalid,
  input  logic                                    arready,
  input  logic [riscv_fetch_pkg::XLEN-1:0]        rdata,
  input  logic [1:0]                              rresp,
  input  logic                                    rvalid,
  output logic                                    rready
);

  import riscv_fetch_pkg::*;

  logic [XLEN-1:0] if_nxt_pc;
  logic            if_stall_nxt_pc;
  // core to bus unit
  logic            biu_stb;
  logic [XLEN-1:0] biu_adri;
  logic            biu_stb_ack;
  logic            biu_rack;
  logic [XLEN-1:0] biu_do;
  logic [XLEN-1:0] biu_adro;
  logic            biu_err;
  // read tracking
  logic            req_taken;
  logic            resp_taken;
  logic            full;
  logic            drop;

  riscv_pc_gen #(
    .reset_pc (reset_pc)
  ) pc_gen_i (
    .clk             (clk),
    .rstn            (rstn),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .if_stall_nxt_pc (if_stall_nxt_pc),
    .if_nxt_pc       (if_nxt_pc)
  );

  // a redirect flushes the parcel queue
  riscv_noicache_core core_i (
    .clk                  (clk),
    .rstn                 (rstn),
    .if_nxt_pc            (if_nxt_pc),
    .if_stall             (if_stall),
    .if_flush             (redirect),
    .dcflush_rdy          (dcflush_rdy),
    .if_stall_nxt_pc      (if_stall_nxt_pc),
    .biu_stb              (biu_stb),
    .biu_adri             (biu_adri),
    .biu_stb_ack          (biu_stb_ack),
    .biu_rack             (biu_rack),
    .biu_do               (biu_do),
    .biu_adro             (biu_adro),
    .biu_err              (biu_err),
    .if_parcel            (if_parcel),
    .if_parcel_pc         (if_parcel_pc),
    .if_parcel_valid      (if_parcel_valid),
    .if_parcel_misaligned (if_parcel_misaligned),
    .if_parcel_err        (if_parcel_err)
  );

  riscv_biu_fsm #(
    .max_outstanding (max_outstanding)
  ) biu_fsm_i (
    .clk         (clk),
    .rstn        (rstn),
    .biu_stb     (biu_stb),
    .biu_adri    (biu_adri),
    .st_prv      (st_prv),
    .full        (full),
    .drop        (drop),
    .biu_stb_ack (biu_stb_ack),
    .biu_rack    (biu_rack),
    .biu_do      (biu_do),
    .biu_adro    (biu_adro),
    .biu_err     (biu_err),
    .req_taken   (req_taken),
    .resp_taken  (resp_taken),
    .araddr      (araddr),
    .arprot      (arprot),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready)
  );

  riscv_inflight_cnt #(
    .max_outstanding (max_outstanding)
  ) inflight_cnt_i (
    .clk        (clk),
    .rstn       (rstn),
    .req_taken  (req_taken),
    .resp_taken (resp_taken),
    .redirect   (redirect),
    .full       (full),
    .drop       (drop)
  );

endmodule

/* riscv_inflight_cnt.sv */
// tracks axi reads that are issued but not yet answered
// full limits new requests, drop marks responses a redirect made stale
// instantiated next to the bus state machine in the fetch top level
module riscv_inflight_cnt #(
  parameter int max_outstanding = 2
) (
  input  logic clk,
  input  logic rstn,
  input  logic req_taken,
  input  logic resp_taken,
  input  logic redirect,
  output logic full,
  output logic drop
);

  // wide enough to hold max_outstanding itself
  localparam int cnt_w = $clog2(max_outstanding + 1);

  logic [cnt_w-1:0] out_cnt;
  logic [cnt_w-1:0] out_nxt;
  logic [cnt_w-1:0] drop_cnt;

  // reads still open after this cycle
  assign out_nxt = out_cnt + cnt_w'(req_taken) - cnt_w'(resp_taken);

  //////////////////////////////////////////////////////////////////////
  // outstanding reads
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      out_cnt <= '0;
    end else begin
      out_cnt <= out_nxt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stale responses
  //////////////////////////////////////////////////////////////////////

  // on redirect every read left open belongs to the old stream
  // a read completing in the redirect cycle is not counted
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      drop_cnt <= '0;
    end else if (redirect) begin
      drop_cnt <= out_nxt;
    end else if (resp_taken && drop_cnt != '0) begin
      drop_cnt <= drop_cnt - 1'b1;
    end
  end

  assign full = (out_cnt == cnt_w'(max_outstanding));
  assign drop = (drop_cnt != '0);

endmodule

/* riscv_noicache_core.sv */
// fetch engine for a core without instruction cache
// gates fetch requests toward the bus unit and buffers returned
// parcels in a three-entry shifting queue until the cpu takes them
module riscv_noicache_core (
  input  logic                                    clk,
  input  logic                                    rstn,
  input  logic [riscv_fetch_pkg::XLEN-1:0]        if_nxt_pc,
  input  logic                                    if_stall,
  input  logic                                    if_flush,
  input  logic                                    dcflush_rdy,
  output logic                                    if_stall_nxt_pc,
  output logic                                    biu_stb,
  output logic [riscv_fetch_pkg::XLEN-1:0]        biu_adri,
  input  logic                                    biu_stb_ack,
  input  logic                                    biu_rack,
  input  logic [riscv_fetch_pkg::XLEN-1:0]        biu_do,
  input  logic [riscv_fetch_pkg::XLEN-1:0]        biu_adro,
  input  logic                                    biu_err,
  output logic [riscv_fetch_pkg::parcel_size-1:0] if_parcel,
  output logic [riscv_fetch_pkg::XLEN-1:0]        if_parcel_pc,
  output logic                                    if_parcel_valid,
  output logic                                    if_parcel_misaligned,
  output logic                                    if_parcel_err
);

  import riscv_fetch_pkg::*;

  // queue entries, index 0 is the head
  // q_valid is a fill level, bit n set means entries 0..n hold data
  logic [2:0]             q_valid;
  logic [parcel_size-1:0] q_dat [3];
  logic [XLEN-1:0]        q_adr [3];
  logic [2:0]             q_err;

  logic                   if_flush_dly;
  logic [1:0]             fill_lvl;
  logic [1:0]             wr_idx;

  //////////////////////////////////////////////////////////////////////
  // flush
  //////////////////////////////////////////////////////////////////////

  // parcels stay blocked one more cycle after a redirect
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      if_flush_dly <= 1'b0;
    end else begin
      if_flush_dly <= if_flush;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // request gating
  //////////////////////////////////////////////////////////////////////

  // hold off while the data cache flushes, on redirect, on stall,
  // or when entry 1 is taken and two more reads could still land
  assign biu_stb  = dcflush_rdy & ~if_flush & ~if_stall & ~q_valid[1];
  assign biu_adri = if_nxt_pc;

  // pc only moves when its address went out on the bus
  assign if_stall_nxt_pc = ~(biu_stb & biu_stb_ack);

  //////////////////////////////////////////////////////////////////////
  // toward the cpu
  //////////////////////////////////////////////////////////////////////

  assign if_parcel_valid = dcflush_rdy & ~(if_flush | if_flush_dly) & ~if_stall & q_valid[0];
  assign if_parcel       = q_dat[0];
  assign if_parcel_pc    = q_adr[0];
  assign if_parcel_err   = q_err[0];

  // compressed parcels unsupported, any low address bit is flagged
  assign if_parcel_misaligned = |if_parcel_pc[1:0];

  //////////////////////////////////////////////////////////////////////
  // parcel queue
  //////////////////////////////////////////////////////////////////////

  // number of entries in use
  always_comb begin
    if (q_valid[2]) begin
      fill_lvl = 2'd3;
    end else if (q_valid[1]) begin
      fill_lvl = 2'd2;
    end else if (q_valid[0]) begin
      fill_lvl = 2'd1;
    end else begin
      fill_lvl = 2'd0;
    end
  end

  // a read in the same cycle shifts everything down one slot first
  assign wr_idx = fill_lvl - 2'(if_parcel_valid);

  // valid bits, cleared at the redirect edge
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      q_valid <= '0;
    end else if (if_flush) begin
      q_valid <= '0;
    end else begin
      case ({biu_rack, if_parcel_valid})
        // write only, raise the next level
        2'b10:   q_valid <= {q_valid[1:0], 1'b1};
        // read only, drop one level
        2'b01:   q_valid <= {1'b0, q_valid[2:1]};
        // read and write together leave the level unchanged
        default: q_valid <= q_valid;
      endcase
    end
  end

  // payload, shifted on read and written at the fill point
  always_ff @(posedge clk) begin
    if (if_parcel_valid) begin
      for (int i = 0; i < 2; i++) begin
        q_dat[i] <= q_dat[i+1];
        q_adr[i] <= q_adr[i+1];
        q_err[i] <= q_err[i+1];
      end
    end
    if (biu_rack) begin
      q_dat[wr_idx] <= biu_do;
      q_adr[wr_idx] <= biu_adro;
      q_err[wr_idx] <= biu_err;
    end
  end

endmodule

/* riscv_pc_gen.sv */
// next fetch address register
// starts at the reset vector, steps one parcel per accepted request
// and loads the target on a redirect from the cpu
module riscv_pc_gen #(
  parameter logic [riscv_fetch_pkg::XLEN-1:0] reset_pc = '0
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              redirect,
  input  logic [riscv_fetch_pkg::XLEN-1:0]  redirect_pc,
  input  logic                              if_stall_nxt_pc,
  output logic [riscv_fetch_pkg::XLEN-1:0]  if_nxt_pc
);

  import riscv_fetch_pkg::*;

  // one parcel in bytes
  localparam logic [XLEN-1:0] pc_step = XLEN'(parcel_size / 8);

  //////////////////////////////////////////////////////////////////////
  // fetch address
  //////////////////////////////////////////////////////////////////////

  // redirect wins over the sequential step
  // step only when the core has handed the address to the bus
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      if_nxt_pc <= reset_pc;
    end else if (redirect) begin
      if_nxt_pc <= redirect_pc;
    end else if (!if_stall_nxt_pc) begin
      if_nxt_pc <= if_nxt_pc + pc_step;
    end
  end

endmodule
